// File: cdr_cfg_pkg.sv
package cdr_cfg_pkg;

  // oversamples delivered per unit interval
  localparam int SAMPLES_PER_UI = 8;

  // sample index within one word
  localparam int IDX_W = $clog2(SAMPLES_PER_UI);

  // fractional phase bits below the index
  // these set the loop integration depth
  localparam int FRAC_W = 8;

  // whole phase code, index on top of fraction
  localparam int CODE_W = IDX_W + FRAC_W;

  // code after reset
  // index 0, zero fraction
  localparam logic [CODE_W-1:0] CODE_RESET = '0;

endpackage

// File: cdr_types_pkg.sv
package cdr_types_pkg;

  import cdr_cfg_pkg::*;

  // one oversampled unit interval from the front end
  typedef struct packed {
    logic                      valid;
    logic [SAMPLES_PER_UI-1:0] samples;
  } rx_word_t;

  // edge and data bit picked from the window
  typedef struct packed {
    logic valid;
    logic edge_bit;
    logic data_bit;
  } sample_pair_t;

  // detector output, up and dn exclusive
  typedef struct packed {
    logic valid;
    logic up;
    logic dn;
  } pd_result_t;

  // block vote from the voter
  typedef struct packed {
    logic valid;
    logic up;
    logic dn;
  } vote_t;

  // split view of the phase code
  typedef struct packed {
    logic [IDX_W-1:0]  idx;
    logic [FRAC_W-1:0] frac;
  } phase_fields_t;

  // raw for the accumulator, fields for the picker
  typedef union packed {
    logic [CODE_W-1:0] raw;
    phase_fields_t     fields;
  } phase_code_u;

endpackage

// File: phase_picker.sv
`timescale 1ns/1ps

module phase_picker
  import cdr_cfg_pkg::*;
  import cdr_types_pkg::*;
(
  input  logic         PI_CLK_OUT,
  input  logic         reset,
  input  rx_word_t     rx,
  input  phase_code_u  code,
  output sample_pair_t pair
);

  // window spans two words
  localparam int WIN_W = 2 * SAMPLES_PER_UI;
  localparam int POS_W = IDX_W + 1;

  // data sample sits half a UI after the edge
  localparam logic [POS_W-1:0] HALF_UI = POS_W'(SAMPLES_PER_UI / 2);

  // last accepted word
  logic [SAMPLES_PER_UI-1:0] prev_word;

  logic [WIN_W-1:0] window;
  logic [POS_W-1:0] edge_pos;
  logic [POS_W-1:0] data_pos;

  // previous word low, current word high
  assign window = {rx.samples, prev_word};

  // only the index field steers the pick
  assign edge_pos = {1'b0, code.fields.idx};
  assign data_pos = edge_pos + HALF_UI;

  always_ff @(posedge PI_CLK_OUT) begin
    if (reset) begin
      pair.valid <= 1'b0;
      prev_word  <= '0;
    end else begin
      // strobe follows rx by one cycle
      pair.valid <= rx.valid;
      if (rx.valid) begin
        prev_word <= rx.samples;
      end
    end
  end

  // payload only moves on a valid word
  always_ff @(posedge PI_CLK_OUT) begin
    if (rx.valid) begin
      pair.edge_bit <= window[edge_pos];
      pair.data_bit <= window[data_pos];
    end
  end

endmodule

// File: bang_bang_pd.sv
`timescale 1ns/1ps

module bang_bang_pd
  import cdr_types_pkg::*;
(
  input  logic         PI_CLK_OUT,
  input  logic         reset,
  input  sample_pair_t pair,
  output pd_result_t   result
);

  // data bit of the previous pair
  logic d0;
  // set once a first pair has been seen
  logic have_prev;

  logic d1;
  logic e;
  logic transition;
  logic late;
  logic early;

  assign d1 = pair.data_bit;
  assign e  = pair.edge_bit;

  // no transition means no phase information
  assign transition = have_prev && (d0 != d1);

  // edge already shows the new bit
  // so the sampling clock is behind
  assign late = transition && (e == d1);

  // edge still shows the old bit
  assign early = transition && (e != d1);

  always_ff @(posedge PI_CLK_OUT) begin
    if (reset) begin
      have_prev <= 1'b0;
      d0        <= 1'b0;
    end else if (pair.valid) begin
      have_prev <= 1'b1;
      d0        <= d1;
    end
  end

  always_ff @(posedge PI_CLK_OUT) begin
    if (reset) begin
      result <= '0;
    end else begin
      // one result strobe per pair
      // decision may be empty
      result.valid <= pair.valid;
      if (pair.valid) begin
        result.up <= early;
        result.dn <= late;
      end else begin
        result.up <= 1'b0;
        result.dn <= 1'b0;
      end
    end
  end

endmodule

// File: box_car_voter.sv
`timescale 1ns/1ps

module box_car_voter
  import cdr_types_pkg::*;
#(
  parameter int NUMBER_SAMPLES = 4
) (
  input  logic       PI_CLK_OUT,
  input  logic       reset,
  input  pd_result_t result,
  output vote_t      vote
);

  // counter must hold NUMBER_SAMPLES-1
  localparam int CNT_W = (NUMBER_SAMPLES > 1) ? $clog2(NUMBER_SAMPLES) : 1;
  // sum ranges over +/- NUMBER_SAMPLES
  localparam int SUM_W = $clog2(NUMBER_SAMPLES + 1) + 1;

  logic [CNT_W-1:0]        count;
  logic signed [SUM_W-1:0] sum;
  logic signed [SUM_W-1:0] sum_next;
  logic                    last;

  // running up minus dn including this result
  always_comb begin
    sum_next = sum;
    if (result.up) begin
      sum_next = sum + SUM_W'(1);
    end else if (result.dn) begin
      sum_next = sum - SUM_W'(1);
    end
  end

  // final result of the current block
  assign last = (count == CNT_W'(NUMBER_SAMPLES - 1));

  always_ff @(posedge PI_CLK_OUT) begin
    if (reset) begin
      count <= '0;
      sum   <= '0;
      vote  <= '0;
    end else begin
      vote.valid <= 1'b0;
      vote.up    <= 1'b0;
      vote.dn    <= 1'b0;
      if (result.valid) begin
        if (last) begin
          // majority decides, a tie gives no vote
          vote.valid <= 1'b1;
          vote.up    <= (sum_next > 0);
          vote.dn    <= (sum_next < 0);
          count      <= '0;
          sum        <= '0;
        end else begin
          count <= count + CNT_W'(1);
          sum   <= sum_next;
        end
      end
    end
  end

endmodule

// File: digital_loop_filter.sv
`timescale 1ns/1ps

module digital_loop_filter
  import cdr_cfg_pkg::*;
  import cdr_types_pkg::*;
#(
  parameter int STEP = 32
) (
  input  logic        PI_CLK_OUT,
  input  logic        reset,
  input  vote_t       vote,
  output phase_code_u code
);

  // increment per vote in raw code units
  localparam logic [CODE_W-1:0] STEP_RAW = CODE_W'(STEP);

  logic [CODE_W-1:0] raw_next;

  // wrapping add or subtract on the raw view
  // carries out of the top simply drop
  always_comb begin
    raw_next = code.raw;
    if (vote.valid) begin
      if (vote.up) begin
        raw_next = code.raw + STEP_RAW;
      end else if (vote.dn) begin
        raw_next = code.raw - STEP_RAW;
      end
    end
  end

  // fraction integrates, idx moves only
  // after enough votes in one direction
  always_ff @(posedge PI_CLK_OUT) begin
    if (reset) begin
      code.raw <= CODE_RESET;
    end else begin
      code.raw <= raw_next;
    end
  end

endmodule

// File: cdr_loop.sv
`timescale 1ns/1ps

module cdr_loop
  import cdr_types_pkg::*;
#(
  parameter int NUMBER_SAMPLES = 4,
  parameter int STEP           = 32
) (
  input  logic        PI_CLK_OUT,
  input  logic        reset,
  input  rx_word_t    rx,
  output logic        dout,
  output logic        dout_valid,
  output phase_code_u phase_code
);

  sample_pair_t pair;
  pd_result_t   result;
  vote_t        vote;

  // picker stands in for the phase interpolator
  phase_picker u_picker (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset),
    .rx         (rx),
    .code       (phase_code),
    .pair       (pair)
  );

  // alexander early/late
  bang_bang_pd u_pd (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset),
    .pair       (pair),
    .result     (result)
  );

  // block majority over NUMBER_SAMPLES results
  box_car_voter #(
    .NUMBER_SAMPLES (NUMBER_SAMPLES)
  ) u_voter (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset),
    .result     (result),
    .vote       (vote)
  );

  // code feeds back to the picker
  digital_loop_filter #(
    .STEP (STEP)
  ) u_filter (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset),
    .vote       (vote),
    .code       (phase_code)
  );

  // recovered bit is the picked data sample
  assign dout       = pair.data_bit;
  assign dout_valid = pair.valid;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic PI_CLK_OUT,
  output logic reset
);

  // 10 ns period
  initial begin
    PI_CLK_OUT = 1'b0;
    forever #5 PI_CLK_OUT = ~PI_CLK_OUT;
  end

  // reset released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge PI_CLK_OUT);
    reset <= 1'b0;
  end

endmodule

// File: cdr_checker.sv
`timescale 1ns/1ps

module cdr_checker
  import cdr_types_pkg::*;
(
  input logic        PI_CLK_OUT,
  input logic        reset,
  input rx_word_t    rx,
  input pd_result_t  result,
  input vote_t       vote,
  input logic        dout_valid,
  input phase_code_u phase_code
);

  // vote carries at most one direction
  vote_exclusive: assert property (
    @(posedge PI_CLK_OUT) disable iff (reset) !(vote.up && vote.dn)
  ) else $error("vote has up and dn set together");

  // same rule at the detector
  result_exclusive: assert property (
    @(posedge PI_CLK_OUT) disable iff (reset) !(result.up && result.dn)
  ) else $error("detector result has up and dn set together");

  // picker latency is one cycle
  rx_to_dout: assert property (
    @(posedge PI_CLK_OUT) disable iff (reset) rx.valid |=> dout_valid
  ) else $error("dout_valid missing one cycle after rx valid");

  // code only moves after a deciding vote
  code_after_vote: assert property (
    @(posedge PI_CLK_OUT) disable iff (reset)
      (phase_code.raw != $past(phase_code.raw))
        |-> $past(vote.valid && (vote.up || vote.dn))
  ) else $error("phase_code changed without a preceding up or dn vote");

endmodule

bind cdr_loop cdr_checker u_checker (
  .PI_CLK_OUT (PI_CLK_OUT),
  .reset      (reset),
  .rx         (rx),
  .result     (result),
  .vote       (vote),
  .dout_valid (dout_valid),
  .phase_code (phase_code)
);

// File: cdr_tb.sv
`timescale 1ns/1ps

module cdr_tb
  import cdr_cfg_pkg::*;
  import cdr_types_pkg::*;
();

  localparam int MAX_CYCLES   = 6000;
  localparam int MAX_WORDS    = 8192;
  localparam int LOCK_WORDS   = 1500;
  localparam int SEARCH_WORDS = 24;
  localparam int RUN_WORDS    = 200;
  localparam int SETTLE_WORDS = 16;
  localparam int QUIET_WORDS  = 300;

  logic        PI_CLK_OUT;
  logic        reset;
  rx_word_t    rx;
  logic        dout;
  logic        dout_valid;
  phase_code_u phase_code;

  // transmitter model state
  integer seed = 73142;
  logic   prev_bit = 1'b0;
  int     offset = 5;
  logic   tx_bits [0:MAX_WORDS-1];
  logic   out_bits [0:MAX_WORDS-1];
  int     word_count = 0;
  int     out_count = 0;
  int     cycle_count = 0;
  int     checks = 0;
  int     errors = 0;
  bit     watch_pd = 1'b0;
  int     pd_decisions = 0;

  tb_clock_gen u_clk (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset)
  );

  cdr_loop uut (
    .PI_CLK_OUT (PI_CLK_OUT),
    .reset      (reset),
    .rx         (rx),
    .dout       (dout),
    .dout_valid (dout_valid),
    .phase_code (phase_code)
  );

  // capture recovered bits, one per valid word
  always @(negedge PI_CLK_OUT) begin
    if (!reset && dout_valid) begin
      if (out_count < MAX_WORDS) begin
        out_bits[out_count] = dout;
      end
      out_count++;
    end
    // detector decisions while watched
    if (watch_pd && uut.result.valid && (uut.result.up || uut.result.dn)) begin
      pd_decisions++;
    end
  end

  // run limit
  always @(posedge PI_CLK_OUT) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // four-state compare, so unknown outputs count as wrong
  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("error %s: expected %0d, actual %0d", test, expected, actual);
      errors++;
    end
  endtask

  // circular distance on the sample index
  task automatic check_near(input string test, input int expected, input int actual);
    int d;
    d = (actual - expected + SAMPLES_PER_UI) % SAMPLES_PER_UI;
    if (d > SAMPLES_PER_UI / 2) begin
      d = SAMPLES_PER_UI - d;
    end
    checks++;
    assert (d <= 1) else begin
      $display("error %s: expected idx %0d +/-1, actual %0d", test, expected, actual);
      errors++;
    end
  endtask

  // samples below k hold the old bit
  function automatic logic [SAMPLES_PER_UI-1:0] make_word(input logic old_bit,
                                                          input logic new_bit,
                                                          input int k);
    logic [SAMPLES_PER_UI-1:0] w;
    for (int j = 0; j < SAMPLES_PER_UI; j++) begin
      w[j] = (j < k) ? old_bit : new_bit;
    end
    return w;
  endfunction

  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic send_word(input logic b);
    logic [SAMPLES_PER_UI-1:0] w;
    w = make_word(prev_bit, b, offset);
    @(posedge PI_CLK_OUT);
    rx.valid   <= 1'b1;
    rx.samples <= w;
    if (word_count < MAX_WORDS) begin
      tx_bits[word_count] = b;
    end
    word_count++;
    prev_bit = b;
  endtask

  task automatic drive_gap();
    @(posedge PI_CLK_OUT);
    rx.valid <= 1'b0;
  endtask

  // random bits, optional idle cycles between words
  task automatic send_random(input int n, input bit gaps);
    int r;
    repeat (n) begin
      r = $random(seed);
      if (gaps && r[2:0] == 3'd0) begin
        drive_gap();
      end
      send_word(random_bit());
    end
    drive_gap();
  endtask

  task automatic wait_outputs(input int n);
    while (out_count < n) begin
      @(posedge PI_CLK_OUT);
    end
  endtask

  function automatic bit window_matches(input int lo, input int hi, input int d);
    for (int n = lo; n < hi; n++) begin
      if (tx_bits[n-d] !== out_bits[n]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic reset_state();
    // first edge applies the synchronous reset
    @(posedge PI_CLK_OUT);
    while (reset) begin
      @(negedge PI_CLK_OUT);
      check_value("reset_state", 0, dout_valid);
      check_value("reset_state", CODE_RESET, phase_code.raw);
    end
    // idle cycles just after release
    repeat (3) begin
      @(negedge PI_CLK_OUT);
      check_value("reset_state", 0, dout_valid);
      check_value("reset_state", CODE_RESET, phase_code.raw);
    end
  endtask

  // move the transition and let the loop settle
  task automatic relock(input string test, input int k);
    offset = k;
    send_random(LOCK_WORDS, 1'b0);
    wait_outputs(word_count);
    @(negedge PI_CLK_OUT);
    check_near(test, k % SAMPLES_PER_UI, int'(phase_code.fields.idx));
  endtask

  task automatic data_recovery(input string test);
    int first;
    int delay;
    first = word_count;
    send_random(SEARCH_WORDS, 1'b1);
    wait_outputs(word_count);
    // latency of one or two words
    delay = 0;
    for (int d = 1; d <= 2; d++) begin
      if (delay == 0 && window_matches(first, word_count, d)) begin
        delay = d;
      end
    end
    checks++;
    assert (delay != 0) else begin
      $display("%s: recovered data matches neither a 1 nor a 2 word latency", test);
      errors++;
    end
    if (delay != 0) begin
      first = word_count;
      send_random(RUN_WORDS, 1'b1);
      wait_outputs(word_count);
      for (int n = first; n < word_count; n++) begin
        check_value(test, int'(tx_bits[n-delay]), int'(out_bits[n]));
      end
    end
    // one output per word, none extra
    repeat (3) @(posedge PI_CLK_OUT);
    check_value(test, word_count, out_count);
  endtask

  task automatic no_transitions();
    phase_code_u start_code;
    logic level;
    level = prev_bit;
    // flush decisions and the open voter block
    repeat (SETTLE_WORDS) send_word(level);
    drive_gap();
    wait_outputs(word_count);
    repeat (4) @(posedge PI_CLK_OUT);
    pd_decisions = 0;
    watch_pd = 1'b1;
    @(negedge PI_CLK_OUT);
    start_code = phase_code;
    repeat (QUIET_WORDS) send_word(level);
    drive_gap();
    wait_outputs(word_count);
    repeat (4) @(posedge PI_CLK_OUT);
    watch_pd = 1'b0;
    @(negedge PI_CLK_OUT);
    check_value("no_transitions", int'(start_code.raw), int'(phase_code.raw));
    check_value("no_transitions", 0, pd_decisions);
  endtask

  initial begin
    rx = '0;
    seed = 73142;
    reset_state();
    relock("lock_offset", 5);
    data_recovery("data_recovery");
    relock("phase_step", 1);
    data_recovery("phase_step");
    no_transitions();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: build.f
cdr_cfg_pkg.sv
cdr_types_pkg.sv
phase_picker.sv
bang_bang_pd.sv
box_car_voter.sv
digital_loop_filter.sv
cdr_loop.sv
tb_clock_gen.sv
cdr_checker.sv
cdr_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := cdr_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
